// ==== filelist.f ====
decode_pkg.sv
op_decoder.sv
imm_gen.sv
hazard_unit.sv
issue_register.sv
decode_stage.sv
tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - op_decoder.sv
  - imm_gen.sv
  - hazard_unit.sv
  - issue_register.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage
    import decode_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 6000;
    localparam logic [31:0] SEED           = 32'h0c2e_3035;

    typedef struct packed {
        op_e       op;
        word_t     first;
        word_t     second;
        word_t     third;
        word_t     pc;
        word_t     instr;
        reg_addr_t rd;
        tag_t      tag;
        logic      illegal;
        logic      misaligned;
        logic      fault;
    } expect_t;

    logic      clk;
    logic      reset_n;
    logic      valid_i;
    word_t     instruction_i;
    word_t     pc_i;
    tag_t      tag_i;
    logic      access_fault_i;
    logic      rollback_i;
    reg_addr_t rs1_o;
    reg_addr_t rs2_o;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    logic      hazard_o;
    logic      valid_o;
    op_e       operation_o;
    word_t     first_operand_o;
    word_t     second_operand_o;
    word_t     third_operand_o;
    word_t     pc_o;
    word_t     instruction_o;
    reg_addr_t rd_o;
    tag_t      tag_o;
    logic      illegal_o;
    logic      misaligned_o;
    logic      access_fault_o;

    // Instruction being formed and its expected decode
    word_t     g_instr;
    op_e       g_op;
    format_e   g_fmt;
    word_t     g_imm;
    logic      g_illegal;

    // Reference view of the hazard lock
    reg_addr_t lock_rd;
    logic      lock_store;
    logic      seen_hazard;
    expect_t   exp_q[$];
    int        cycle_count;

    op_e        alu_ops [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
    logic [2:0] alu_f3  [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] alu_f7  [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                                 7'h00, 7'h00};
    op_e        br_ops  [6]  = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    logic [2:0] br_f3   [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    op_e        ld_ops  [5]  = '{LB, LH, LW, LBU, LHU};
    logic [2:0] ld_f3   [5]  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    op_e        st_ops  [3]  = '{SB, SH, SW};

    decode_stage UUT (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Register file model, x0 reads zero
    function automatic word_t reg_value(input reg_addr_t r);
        return word_t'(r) * 32'h0101_0101;
    endfunction

    always_comb rs1_data_i = reg_value(rs1_o);
    always_comb rs2_data_i = reg_value(rs2_o);

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic report_failure;
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        assert (got === want) else begin
            $display("Error: %s is %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (reset_n && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("valid_o was raised with no instruction outstanding");
                report_failure();
            end else begin
                e = exp_q.pop_front();
                check_word("operation_o", word_t'(operation_o), word_t'(e.op));
                check_word("first_operand_o", first_operand_o, e.first);
                check_word("second_operand_o", second_operand_o, e.second);
                check_word("third_operand_o", third_operand_o, e.third);
                check_word("pc_o", pc_o, e.pc);
                check_word("instruction_o", instruction_o, e.instr);
                check_word("rd_o", rd_o, e.rd);
                check_word("tag_o", tag_o, e.tag);
                check_word("illegal_o", illegal_o, e.illegal);
                check_word("misaligned_o", misaligned_o, e.misaligned);
                check_word("access_fault_o", access_fault_o, e.fault);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    //////////////////////////////
    // Instruction forming
    //////////////////////////////

    task automatic form_r(input op_e op, input logic [6:0] f7, input logic [2:0] f3,
                          input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                          input opcode_t opc);
        g_instr   = {f7, rs2, rs1, f3, rd, opc};
        g_op      = op;
        g_fmt     = R_TYPE;
        g_imm     = '0;
        g_illegal = (op == INVALID);
    endtask

    task automatic form_i(input op_e op, input logic [11:0] imm, input logic [2:0] f3,
                          input reg_addr_t rd, input reg_addr_t rs1, input opcode_t opc);
        g_instr   = {imm, rs1, f3, rd, opc};
        g_op      = op;
        g_fmt     = I_TYPE;
        g_imm     = {{20{imm[11]}}, imm};
        g_illegal = (op == INVALID);
    endtask

    task automatic form_s(input op_e op, input logic [11:0] imm, input logic [2:0] f3,
                          input reg_addr_t rs1, input reg_addr_t rs2);
        g_instr   = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
        g_op      = op;
        g_fmt     = S_TYPE;
        g_imm     = {{20{imm[11]}}, imm};
        g_illegal = 1'b0;
    endtask

    // Offset bit 0 is never encoded
    task automatic form_b(input op_e op, input logic [12:0] imm, input logic [2:0] f3,
                          input reg_addr_t rs1, input reg_addr_t rs2);
        g_instr   = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
        g_op      = op;
        g_fmt     = B_TYPE;
        g_imm     = {{19{imm[12]}}, imm[12:1], 1'b0};
        g_illegal = 1'b0;
    endtask

    task automatic form_u(input op_e op, input logic [19:0] upper, input reg_addr_t rd,
                          input opcode_t opc);
        g_instr   = {upper, rd, opc};
        g_op      = op;
        g_fmt     = U_TYPE;
        g_imm     = {upper, 12'b0};
        g_illegal = 1'b0;
    endtask

    task automatic form_j(input logic [20:0] imm, input reg_addr_t rd);
        g_instr   = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
        g_op      = JAL;
        g_fmt     = J_TYPE;
        g_imm     = {{11{imm[20]}}, imm[20:1], 1'b0};
        g_illegal = 1'b0;
    endtask

    // Sources from x0..x15 and destinations from x16..x31 keep these free of dependences
    task automatic random_alu;
        int    k;
        int    i;
        word_t r;
        r = $urandom;
        k = $urandom_range(0, 5);
        i = $urandom_range(0, 9);
        case (k)
            0: form_r(alu_ops[i], alu_f7[i], alu_f3[i], r[31:27] | 5'h10, r[19:15] & 5'h0f,
                      r[24:20] & 5'h0f, OPC_OP);
            1: begin
                if (i == 1)
                    i = 0;
                if (alu_f3[i] == 3'd1 || alu_f3[i] == 3'd5)
                    r[31:25] = alu_f7[i];
                form_i(alu_ops[i], r[31:20], alu_f3[i], r[11:7] | 5'h10, r[19:15] & 5'h0f,
                       OPC_OP_IMM);
            end
            2: form_u(LUI, r[31:12], r[11:7] | 5'h10, OPC_LUI);
            3: form_u(ADD, r[31:12], r[11:7] | 5'h10, OPC_AUIPC);
            4: form_j(r[20:0], r[31:27] | 5'h10);
            default: form_i(JALR, r[31:20], 3'd0, r[11:7] | 5'h10, r[19:15] & 5'h0f, OPC_JALR);
        endcase
    endtask

    task automatic random_memory;
        word_t r;
        r = $urandom;
        case ($urandom_range(0, 2))
            0: form_b(br_ops[r[2:0] % 6], r[31:19], br_f3[r[2:0] % 6], r[14:10] & 5'h0f,
                      r[9:5] & 5'h0f);
            1: form_i(ld_ops[r[2:0] % 5], r[31:20], ld_f3[r[2:0] % 5], r[9:5] | 5'h10,
                      r[14:10] & 5'h0f, OPC_LOAD);
            default: form_s(st_ops[r[1:0] % 3], r[31:20], st_f3(r[1:0] % 3),
                            r[14:10] & 5'h0f, r[9:5] & 5'h0f);
        endcase
    endtask

    function automatic logic [2:0] st_f3(input int i);
        return 3'(i);
    endfunction

    task automatic random_faulty;
        word_t r;
        r = $urandom;
        case ($urandom_range(0, 3))
            // Opcodes with no RV32I meaning
            0: form_r(INVALID, r[31:25], r[14:12], r[11:7], r[19:15], r[24:20],
                      r[0] ? 7'b1111111 : 7'b0001011);
            1: form_i(INVALID, r[31:20], (r[1:0] == 2'b00) ? 3'd3 : {2'b11, r[2]}, r[11:7],
                      r[19:15], OPC_LOAD);
            2: form_r(INVALID, 7'h01, r[14:12], r[11:7], r[19:15], r[24:20], OPC_OP);
            default: random_alu();
        endcase
    endtask

    //////////////////////////////
    // Driving
    //////////////////////////////

    task automatic send_instruction(input word_t pc, input tag_t tag, input logic fault,
                                    input logic rb);
        expect_t   e;
        logic      hz;
        reg_addr_t rs1;
        reg_addr_t rs2;
        rs1 = g_instr[19:15];
        rs2 = g_instr[24:20];
        hz = !rb && ((g_fmt inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE} && rs1 != 0
                      && rs1 == lock_rd)
                  || (g_fmt inside {R_TYPE, S_TYPE, B_TYPE} && rs2 != 0 && rs2 == lock_rd)
                  || (g_instr[6:0] == OPC_LOAD && lock_store));
        e = '0;
        e.op = NOP;
        e.tag = tag;
        if (hz || rb) begin
            lock_rd = '0;
            lock_store = 1'b0;
        end else begin
            e.op = g_op;
            e.first = (g_fmt inside {U_TYPE, J_TYPE}) ? pc : reg_value(rs1);
            e.second = (g_fmt inside {R_TYPE, B_TYPE}) ? reg_value(rs2) : g_imm;
            e.third = (g_fmt == S_TYPE) ? reg_value(rs2) : g_imm;
            e.pc = pc;
            e.instr = g_instr;
            e.rd = g_instr[11:7];
            e.illegal = g_illegal;
            e.misaligned = (pc[1:0] != 2'b00);
            e.fault = fault;
            lock_rd = g_instr[11:7];
            lock_store = (g_instr[6:0] == OPC_STORE);
        end
        exp_q.push_back(e);
        @(posedge clk);
        valid_i        <= 1'b1;
        instruction_i  <= g_instr;
        pc_i           <= pc;
        tag_i          <= tag;
        access_fault_i <= fault;
        rollback_i     <= rb;
        @(negedge clk);
        seen_hazard = hazard_o;
        check_word("hazard_o", hazard_o, hz);
        check_word("rs1_o", rs1_o, rs1);
        check_word("rs2_o", rs2_o, rs2);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i    <= 1'b0;
            rollback_i <= 1'b0;
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        word_t r;
        void'($urandom(SEED));
        reset_n        = 1'b0;
        valid_i        = 1'b0;
        instruction_i  = '0;
        pc_i           = '0;
        tag_i          = '0;
        access_fault_i = 1'b0;
        rollback_i     = 1'b0;
        lock_rd        = '0;
        lock_store     = 1'b0;
        cycle_count    = 0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_word("valid_o", valid_o, 1'b0);
        check_word("operation_o", word_t'(operation_o), word_t'(NOP));
        check_word("illegal_o", illegal_o, 1'b0);
        check_word("misaligned_o", misaligned_o, 1'b0);
        check_word("access_fault_o", access_fault_o, 1'b0);

        // ALU, upper immediates and jumps
        repeat (600) begin
            random_alu();
            r = $urandom;
            send_instruction({r[31:2], 2'b00}, r[2:0], 1'b0, 1'b0);
            idle_cycles($urandom_range(0, 2));
        end

        // Branches, loads and stores
        repeat (500) begin
            random_memory();
            r = $urandom;
            send_instruction({r[31:2], 2'b00}, r[4:2], 1'b0, 1'b0);
            idle_cycles($urandom_range(0, 2));
        end

        // Illegal encodings, odd pc and access faults
        repeat (400) begin
            random_faulty();
            r = $urandom;
            send_instruction(r, r[6:4], r[8], 1'b0);
            idle_cycles($urandom_range(0, 2));
        end

        // Dependence on the last destination
        idle_cycles(2);
        form_i(ADD, 12'd1, 3'd0, 5'd5, 5'd0, OPC_OP_IMM);
        send_instruction(32'h0000_0100, 3'd1, 1'b0, 1'b0);
        form_r(ADD, 7'h00, 3'd0, 5'd6, 5'd5, 5'd1, OPC_OP);
        send_instruction(32'h0000_0104, 3'd2, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b1);
        send_instruction(32'h0000_0104, 3'd2, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b0);
        // rs2 field matches x6 but I format does not read it
        form_i(ADD, 12'd6, 3'd0, 5'd7, 5'd0, OPC_OP_IMM);
        send_instruction(32'h0000_0108, 3'd3, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b0);
        form_i(ADD, 12'd5, 3'd0, 5'd0, 5'd0, OPC_OP_IMM);
        send_instruction(32'h0000_010c, 3'd4, 1'b0, 1'b0);
        form_r(ADD, 7'h00, 3'd0, 5'd9, 5'd0, 5'd0, OPC_OP);
        send_instruction(32'h0000_0110, 3'd5, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b0);

        // Load after store
        form_s(SW, 12'h010, 3'd2, 5'd3, 5'd2);
        send_instruction(32'h0000_0114, 3'd6, 1'b0, 1'b0);
        form_i(LW, 12'h004, 3'd2, 5'd10, 5'd11, OPC_LOAD);
        send_instruction(32'h0000_0118, 3'd7, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b1);
        send_instruction(32'h0000_0118, 3'd7, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b0);

        // Rollback masks the hazard and clears the lock
        form_i(ADD, 12'd1, 3'd0, 5'd12, 5'd0, OPC_OP_IMM);
        send_instruction(32'h0000_011c, 3'd0, 1'b0, 1'b0);
        form_r(SUB, 7'h20, 3'd0, 5'd13, 5'd12, 5'd12, OPC_OP);
        send_instruction(32'h0000_0120, 3'd1, 1'b0, 1'b1);
        check_word("hazard_o", seen_hazard, 1'b0);
        send_instruction(32'h0000_0120, 3'd2, 1'b0, 1'b0);
        check_word("hazard_o", seen_hazard, 1'b0);
        idle_cycles(4);
        @(negedge clk);

        if (exp_q.size() != 0) begin
            $display("%0d issued instructions never reached the outputs", exp_q.size());
            report_failure();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,

    // Fetch side
    input  logic      valid_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  tag_t      tag_i,
    input  logic      access_fault_i,
    input  logic      rollback_i,

    // Register file
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,

    output logic      hazard_o,

    // Execute side
    output logic      valid_o,
    output op_e       operation_o,
    output word_t     first_operand_o,
    output word_t     second_operand_o,
    output word_t     third_operand_o,
    output word_t     pc_o,
    output word_t     instruction_o,
    output reg_addr_t rd_o,
    output tag_t      tag_o,
    output logic      illegal_o,
    output logic      misaligned_o,
    output logic      access_fault_o
);

    op_e     operation;
    format_e format;
    logic    illegal;
    word_t   immediate;

    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];

    op_decoder u_op_decoder (
        .instruction_i (instruction_i),
        .operation_o   (operation),
        .format_o      (format),
        .illegal_o     (illegal)
    );

    imm_gen u_imm_gen (
        .instruction_i (instruction_i),
        .format_i      (format),
        .immediate_o   (immediate)
    );

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .valid_i       (valid_i),
        .rollback_i    (rollback_i),
        .instruction_i (instruction_i),
        .format_i      (format),
        .hazard_o      (hazard_o)
    );

    issue_register u_issue_register (
        .clk              (clk),
        .reset_n          (reset_n),
        .valid_i          (valid_i),
        .rollback_i       (rollback_i),
        .hazard_i         (hazard_o),
        .instruction_i    (instruction_i),
        .pc_i             (pc_i),
        .immediate_i      (immediate),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .tag_i            (tag_i),
        .access_fault_i   (access_fault_i),
        .operation_i      (operation),
        .format_i         (format),
        .illegal_i        (illegal),
        .valid_o          (valid_o),
        .operation_o      (operation_o),
        .first_operand_o  (first_operand_o),
        .second_operand_o (second_operand_o),
        .third_operand_o  (third_operand_o),
        .pc_o             (pc_o),
        .instruction_o    (instruction_o),
        .rd_o             (rd_o),
        .tag_o            (tag_o),
        .illegal_o        (illegal_o),
        .misaligned_o     (misaligned_o),
        .access_fault_o   (access_fault_o)
    );

endmodule

`default_nettype wire

// ==== issue_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_register
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      valid_i,
    input  logic      rollback_i,
    input  logic      hazard_i,
    input  word_t     instruction_i,
    input  word_t     pc_i,
    input  word_t     immediate_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  tag_t      tag_i,
    input  logic      access_fault_i,
    input  op_e       operation_i,
    input  format_e   format_i,
    input  logic      illegal_i,

    output logic      valid_o,
    output op_e       operation_o,
    output word_t     first_operand_o,
    output word_t     second_operand_o,
    output word_t     third_operand_o,
    output word_t     pc_o,
    output word_t     instruction_o,
    output reg_addr_t rd_o,
    output tag_t      tag_o,
    output logic      illegal_o,
    output logic      misaligned_o,
    output logic      access_fault_o
);

    word_t first_operand;
    word_t second_operand;
    word_t third_operand;
    logic  misaligned;
    logic  bubble;

    //////////////////////////////
    // Operand selection
    //////////////////////////////

    // AUIPC and JAL compute from pc
    assign first_operand = ((format_i == U_TYPE) || (format_i == J_TYPE)) ? pc_i : rs1_data_i;

    assign second_operand = ((format_i == R_TYPE) || (format_i == B_TYPE)) ? rs2_data_i
                                                                           : immediate_i;

    // Store data rides on the third operand
    assign third_operand = (format_i == S_TYPE) ? rs2_data_i : immediate_i;

    assign misaligned = (pc_i[1:0] != 2'b00);
    assign bubble     = hazard_i || rollback_i;

    //////////////////////////////
    // Issue register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o          <= 1'b0;
            operation_o      <= NOP;
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instruction_o    <= '0;
            rd_o             <= '0;
            tag_o            <= '0;
            illegal_o        <= 1'b0;
            misaligned_o     <= 1'b0;
            access_fault_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                // Tag follows the slot even for a bubble
                tag_o <= tag_i;
                if (bubble) begin
                    operation_o      <= NOP;
                    first_operand_o  <= '0;
                    second_operand_o <= '0;
                    third_operand_o  <= '0;
                    pc_o             <= '0;
                    instruction_o    <= '0;
                    rd_o             <= '0;
                    illegal_o        <= 1'b0;
                    misaligned_o     <= 1'b0;
                    access_fault_o   <= 1'b0;
                end else begin
                    operation_o      <= operation_i;
                    first_operand_o  <= first_operand;
                    second_operand_o <= second_operand;
                    third_operand_o  <= third_operand;
                    pc_o             <= pc_i;
                    instruction_o    <= instruction_i;
                    rd_o             <= instruction_i[11:7];
                    illegal_o        <= illegal_i;
                    misaligned_o     <= misaligned;
                    access_fault_o   <= access_fault_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import decode_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    valid_i,
    input  logic    rollback_i,
    input  word_t   instruction_i,
    input  format_e format_i,
    output logic    hazard_o
);

    // Destination and store marker of the last issued instruction
    reg_addr_t locked_register;
    logic      locked_memory;

    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_rs1;
    logic      use_rs2;
    logic      hazard_rs1;
    logic      hazard_rs2;
    logic      hazard_mem;

    assign opcode = instruction_i[6:0];
    assign rs1    = instruction_i[19:15];
    assign rs2    = instruction_i[24:20];
    assign rd     = instruction_i[11:7];

    assign use_rs1 = (format_i == R_TYPE) || (format_i == I_TYPE)
                  || (format_i == S_TYPE) || (format_i == B_TYPE);
    assign use_rs2 = (format_i == R_TYPE) || (format_i == S_TYPE)
                  || (format_i == B_TYPE);

    // x0 never carries a dependence
    assign hazard_rs1 = use_rs1 && (rs1 != '0) && (rs1 == locked_register);
    assign hazard_rs2 = use_rs2 && (rs2 != '0) && (rs2 == locked_register);

    // Load right after a store may read stale memory
    assign hazard_mem = (opcode == OPC_LOAD) && locked_memory;

    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && !rollback_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_register <= '0;
            locked_memory   <= 1'b0;
        end else if (valid_i) begin
            if (hazard_o || rollback_i) begin
                // A bubble writes nothing
                locked_register <= '0;
                locked_memory   <= 1'b0;
            end else begin
                locked_register <= rd;
                locked_memory   <= (opcode == OPC_STORE);
            end
        end
    end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  word_t   instruction_i,
    input  format_e format_i,
    output word_t   immediate_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // All immediates sign-extend from bit 31
    assign imm_i = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_s = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};

    // Branch and jump offsets are in halfwords
    assign imm_b = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_j = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    assign imm_u = {instruction_i[31:12], 12'b0};

    always_comb begin
        case (format_i)
            I_TYPE:  immediate_o = imm_i;
            S_TYPE:  immediate_o = imm_s;
            B_TYPE:  immediate_o = imm_b;
            U_TYPE:  immediate_o = imm_u;
            J_TYPE:  immediate_o = imm_j;
            default: immediate_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== op_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decoder
    import decode_pkg::*;
(
    input  word_t   instruction_i,
    output op_e     operation_o,
    output format_e format_o,
    output logic    illegal_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];

    //////////////////////////////
    // Per-opcode tables
    //////////////////////////////

    op_e branch_op;
    op_e load_op;
    op_e store_op;
    op_e op_imm_op;
    op_e op_op;
    op_e system_op;

    always_comb begin
        case (funct3)
            3'b000:  branch_op = BEQ;
            3'b001:  branch_op = BNE;
            3'b100:  branch_op = BLT;
            3'b101:  branch_op = BGE;
            3'b110:  branch_op = BLTU;
            3'b111:  branch_op = BGEU;
            default: branch_op = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  load_op = LB;
            3'b001:  load_op = LH;
            3'b010:  load_op = LW;
            3'b100:  load_op = LBU;
            3'b101:  load_op = LHU;
            default: load_op = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  store_op = SB;
            3'b001:  store_op = SH;
            3'b010:  store_op = SW;
            default: store_op = INVALID;
        endcase
    end

    // Shift immediates are the only ones that constrain funct7
    always_comb begin
        case ({funct7, funct3}) inside
            10'b???????_000: op_imm_op = ADD;
            10'b0000000_001: op_imm_op = SLL;
            10'b???????_010: op_imm_op = SLT;
            10'b???????_011: op_imm_op = SLTU;
            10'b???????_100: op_imm_op = XOR;
            10'b0000000_101: op_imm_op = SRL;
            10'b0100000_101: op_imm_op = SRA;
            10'b???????_110: op_imm_op = OR;
            10'b???????_111: op_imm_op = AND;
            default:         op_imm_op = INVALID;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_op = ADD;
            10'b0100000_000: op_op = SUB;
            10'b0000000_001: op_op = SLL;
            10'b0000000_010: op_op = SLT;
            10'b0000000_011: op_op = SLTU;
            10'b0000000_100: op_op = XOR;
            10'b0000000_101: op_op = SRL;
            10'b0100000_101: op_op = SRA;
            10'b0000000_110: op_op = OR;
            10'b0000000_111: op_op = AND;
            default:         op_op = INVALID;
        endcase
    end

    // Privileged ops need rs1 and rd both zero
    always_comb begin
        system_op = INVALID;
        case (funct3)
            3'b000: begin
                if (instruction_i[19:7] == '0) begin
                    case (instruction_i[31:20])
                        12'h000: system_op = ECALL;
                        12'h001: system_op = EBREAK;
                        12'h102: system_op = SRET;
                        12'h302: system_op = MRET;
                        12'h105: system_op = WFI;
                        default: system_op = INVALID;
                    endcase
                end
            end
            3'b001:  system_op = CSRRW;
            3'b010:  system_op = CSRRS;
            3'b011:  system_op = CSRRC;
            3'b101:  system_op = CSRRWI;
            3'b110:  system_op = CSRRSI;
            3'b111:  system_op = CSRRCI;
            default: system_op = INVALID;
        endcase
    end

    //////////////////////////////
    // Operation and format select
    //////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = branch_op;
            OPC_LOAD:     operation_o = load_op;
            OPC_STORE:    operation_o = store_op;
            OPC_OP_IMM:   operation_o = op_imm_op;
            OPC_OP:       operation_o = op_op;
            // FENCE has no effect in an in-order core
            OPC_MISC_MEM: operation_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   operation_o = system_op;
            default:      operation_o = INVALID;
        endcase
    end

    assign illegal_o = (operation_o == INVALID);

    always_comb begin
        case (opcode[6:2])
            OPC_JALR[6:2], OPC_LOAD[6:2], OPC_OP_IMM[6:2]: format_o = I_TYPE;
            OPC_STORE[6:2]:                                format_o = S_TYPE;
            OPC_BRANCH[6:2]:                               format_o = B_TYPE;
            OPC_LUI[6:2], OPC_AUIPC[6:2]:                  format_o = U_TYPE;
            OPC_JAL[6:2]:                                  format_o = J_TYPE;
            default:                                       format_o = R_TYPE;
        endcase
    end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;
    localparam int OPCODE_W   = 7;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;

    //////////////////////////////
    // RV32I major opcodes
    //////////////////////////////

    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

    //////////////////////////////
    // Operations and formats
    //////////////////////////////

    typedef enum logic [5:0] {
        // NOP first so the reset value of the register is a bubble
        NOP,
        // ALU
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI,
        // Branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Jumps
        JAL, JALR,
        // Loads and stores
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        // Privileged
        ECALL, EBREAK, MRET, SRET, WFI,
        // CSR access
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

endpackage

`default_nettype wire
